/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP      := bootSystemTb
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* compile.f */
+incdir+hw
hw/memPkg.sv
hw/ctrlPkg.sv
hw/sdReader.sv
hw/bootLoader.sv
hw/memoryMap.sv
hw/wordRam.sv
hw/frameBuffer.sv
hw/bootSystem.sv
dv/clockGen.sv
dv/sdCardModel.sv
dv/bootSystemTb.sv

/* dv/bootSystemTb.sv */
`timescale 1ns/10ps
`include "bootCfg.svh"

module bootSystemTb
    import memPkg::*;
();

    localparam int ImageWords   = 40;
    localparam int ResetTimeout = 20;
    localparam int BootTimeout  = 40000;
    localparam int RandomWrites = 16;
    localparam coord_t LoadX = 8'h12;
    localparam coord_t LoadY = 8'h34;

    logic     clk_25mhz;
    logic     rstN;
    busAddr_t busAddr;
    word_t    busWrData;
    logic     busWrite;
    coord_t   scanX;
    coord_t   scanY;
    logic     sdMiso;
    word_t    busRdData;
    pixel_t   scanPixel;
    logic     booted;
    logic     sdCs;
    logic     sdClk;
    logic     sdMosi;
    int       badCommands;

    int     seed = 21651;
    int     errorCount = 0;
    int     checkCount = 0;
    int     testStart = 0;
    logic   ok;
    pixel_t loadPixelBefore;
    pixel_t loadColor;
    word_t  ramExp [`RAM_WORDS];
    pixel_t pixExp [int];

    clockGen #(.PeriodNs(40), .ResetCycles(5), .DriveDelayNs(2)) clockGenInst (
        .clk  (clk_25mhz),
        .rstN (rstN)
    );

    sdCardModel #(.ImageWords(ImageWords)) cardInst (
        .cs          (sdCs),
        .sclk        (sdClk),
        .mosi        (sdMosi),
        .miso        (sdMiso),
        .badCommands (badCommands)
    );

    bootSystem dut (
        .clk_25mhz (clk_25mhz),
        .rstN      (rstN),
        .busAddr   (busAddr),
        .busWrData (busWrData),
        .busWrite  (busWrite),
        .scanX     (scanX),
        .scanY     (scanY),
        .sdMiso    (sdMiso),
        .busRdData (busRdData),
        .scanPixel (scanPixel),
        .booted    (booted),
        .sdCs      (sdCs),
        .sdClk     (sdClk),
        .sdMosi    (sdMosi)
    );

    // Card word k for k of 1 and up
    function automatic word_t imageWord(input int k);
        imageWord = (word_t'(k) * 32'h0101_0101) ^ 32'hA5A5_A5A5;
    endfunction

    // Inputs change 2 ns after the rising edge
    task automatic nextCycle();
        @(posedge clk_25mhz);
        #2;
    endtask

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic reportTest(input string name);
        $display("%s finished, %0d errors", name, errorCount - testStart);
        testStart = errorCount;
    endtask

    task automatic busWriteCycle(input busAddr_t addr, input word_t data);
        busAddr   = addr;
        busWrData = data;
        busWrite  = 1'b1;
        nextCycle();
        busWrite  = 1'b0;
    endtask

    task automatic readRam(input busAddr_t addr, output word_t data);
        busAddr = addr;
        nextCycle();
        data = busRdData;
    endtask

    task automatic readPixel(input coord_t x, input coord_t y, output pixel_t pixel);
        scanX = x;
        scanY = y;
        nextCycle();
        pixel = scanPixel;
    endtask

    task automatic waitForReset(output logic done);
        int cycles;
        done = 1'b0;
        for (cycles = 0; cycles < ResetTimeout && !done; cycles++) begin
            // rstN is settled at the edge and only moves 2 ns later
            @(posedge clk_25mhz);
            done = rstN;
            #2;
        end
        if (!done) begin
            errorCount++;
            $display("Timeout: reset was never released");
        end
    endtask

    // Counts finished card transfers by the rising edges of sdCs
    task automatic waitCsRises(input int count, output logic done);
        int   cycles;
        int   rises;
        logic lastCs;
        rises  = 0;
        lastCs = sdCs;
        for (cycles = 0; cycles < BootTimeout && rises < count; cycles++) begin
            nextCycle();
            if (sdCs && !lastCs) begin
                rises++;
            end
            lastCs = sdCs;
        end
        done = (rises == count);
        if (!done) begin
            errorCount++;
            $display("Timeout: only %0d of %0d card reads finished", rises, count);
        end
    endtask

    task automatic waitForBoot(output logic done);
        int cycles;
        done = 1'b0;
        for (cycles = 0; cycles < BootTimeout && !done; cycles++) begin
            nextCycle();
            done = booted;
        end
        if (!done) begin
            errorCount++;
            $display("Timeout: booted never rose");
        end
    endtask

    task automatic checkImage();
        word_t got;
        for (int a = 0; a < ImageWords; a++) begin
            ramExp[a] = imageWord(a + 1);
            readRam(busAddr_t'(a), got);
            checkValue("ramContents", ramExp[a], got);
        end
    endtask

    task automatic checkBlockedWrites();
        word_t  got;
        pixel_t pixel;
        readRam(32'h0000_0003, got);
        checkValue("writeDuringLoad ram", imageWord(4), got);
        readPixel(LoadX, LoadY, pixel);
        checkValue("writeDuringLoad pixel", {24'h0, loadPixelBefore}, {24'h0, pixel});
    endtask

    task automatic ramRoundTrip();
        ramAddr_t    addrList [RandomWrites];
        logic [31:0] randVal;
        word_t       got;
        for (int i = 0; i < RandomWrites; i++) begin
            randVal = $random(seed);
            addrList[i] = randVal[9:0];
            randVal = $random(seed);
            ramExp[addrList[i]] = randVal;
            busWriteCycle({22'h0, addrList[i]}, randVal);
        end
        for (int i = 0; i < RandomWrites; i++) begin
            readRam({22'h0, addrList[i]}, got);
            checkValue("ramWrite", ramExp[addrList[i]], got);
        end
    endtask

    task automatic pixelRoundTrip();
        coord_t      xList [RandomWrites];
        coord_t      yList [RandomWrites];
        logic [31:0] randVal;
        pixel_t      pixel;
        word_t       got;
        int          key;
        for (int i = 0; i < RandomWrites; i++) begin
            randVal = $random(seed);
            xList[i] = randVal[7:0];
            yList[i] = randVal[15:8];
            // Upper half must be nonzero for a pixel access
            if ({yList[i], xList[i]} == 16'h0) begin
                xList[i] = 8'h01;
            end
            pixExp[int'({yList[i], xList[i]})] = randVal[23:16];
            busWriteCycle({yList[i], xList[i], 16'h0}, {24'h0, randVal[23:16]});
        end
        for (int i = 0; i < RandomWrites; i++) begin
            readPixel(xList[i], yList[i], pixel);
            checkValue("pixelWrite", {24'h0, pixExp[int'({yList[i], xList[i]})]}, {24'h0, pixel});
        end
        // Both halves nonzero so neither RAM word 5 nor the pixel may change
        key = int'({yList[0], xList[0]});
        busWriteCycle({yList[0], xList[0], 16'h0005}, {~ramExp[5][31:8], ~pixExp[key]});
        readRam(32'h0000_0005, got);
        checkValue("pixelWrite ignored ram", ramExp[5], got);
        readPixel(xList[0], yList[0], pixel);
        checkValue("pixelWrite ignored pixel", {24'h0, pixExp[key]}, {24'h0, pixel});
    endtask

    initial begin
        busAddr   = '0;
        busWrData = '0;
        busWrite  = 1'b0;
        scanX     = '0;
        scanY     = '0;
        waitForReset(ok);
        if (ok) begin
            readPixel(LoadX, LoadY, loadPixelBefore);
            // Header and words 1 to 4 with word 4 landing at RAM address 3
            waitCsRises(5, ok);
        end
        if (ok) begin
            repeat (3) nextCycle();
            checkValue("bootLoad early", 32'h0, {31'h0, booted});
            busWriteCycle(32'h0000_0003, 32'hDEAD_BEEF);
            loadColor = (loadPixelBefore === 8'h5A) ? 8'hC3 : 8'h5A;
            busWriteCycle({LoadY, LoadX, 16'h0}, {24'h0, loadColor});
            waitForBoot(ok);
        end
        if (ok) begin
            checkValue("bootLoad sdCs", 32'h1, {31'h0, sdCs});
            checkValue("bootLoad command", 32'h0, word_t'(badCommands));
            reportTest("bootLoad");
            checkImage();
            reportTest("ramContents");
            checkBlockedWrites();
            reportTest("writeDuringLoad");
            ramRoundTrip();
            reportTest("ramWrite");
            pixelRoundTrip();
            reportTest("pixelWrite");
        end
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* dv/clockGen.sv */
`timescale 1ns/10ps

module clockGen #(
    parameter int PeriodNs     = 40,
    parameter int ResetCycles  = 5,
    parameter int DriveDelayNs = 2
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = !clk;
    end

    // Released shortly after an edge, same as the other inputs
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #(DriveDelayNs) rstN = 1'b1;
    end

endmodule

/* dv/sdCardModel.sv */
`timescale 1ns/10ps
`include "bootCfg.svh"

module sdCardModel #(
    parameter int ImageWords = 40
) (
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso,
    output int   badCommands
);

    logic [23:0] request;
    logic [31:0] reply;

    // Word 0 holds the image size and the rest follow a fixed pattern
    function automatic logic [31:0] cardWord(input logic [15:0] index);
        if (index == 16'h0) begin
            cardWord = 32'(ImageWords);
        end else begin
            cardWord = (32'(index) * 32'h0101_0101) ^ 32'hA5A5_A5A5;
        end
    endfunction

    initial begin
        miso        = 1'b0;
        request     = '0;
        reply       = '0;
        badCommands = 0;
        forever begin
            @(negedge cs);
            // Command byte then card index sampled on rising sclk
            repeat (24) begin
                @(posedge sclk);
                request = {request[22:0], mosi};
            end
            // Only the read command is expected from the reader
            if (request[23:16] != `SD_READ_CMD) begin
                badCommands++;
            end
            reply = cardWord(request[15:0]);
            // New bit after each falling edge for the next rise
            for (int i = 31; i >= 0; i--) begin
                @(negedge sclk);
                miso = reply[i];
            end
            @(posedge cs);
        end
    end

endmodule

/* hw/bootCfg.svh */
`ifndef BOOT_CFG_SVH
`define BOOT_CFG_SVH

// Program RAM depth in 32-bit words
`define RAM_WORDS 1024

// Cycles the loader keeps everything parked after rstN rises
`define RESET_CYCLES 16

// clk_25mhz cycles per sclk half period
`define SPI_HALF_PERIOD 2

// Command byte the card answers with one image word
`define SD_READ_CMD 8'h11

`endif

/* hw/bootLoader.sv */
`timescale 1ns/10ps
`include "bootCfg.svh"

module bootLoader
    import memPkg::*;
    import ctrlPkg::*;
(
    input  logic      clk_25mhz,
    input  logic      rstN,
    input  logic      sdBusy,
    input  logic      sdDone,
    input  word_t     sdData,
    output logic      sdRead,
    output cardAddr_t sdAddr,
    output logic      loading,
    output logic      ldWrite,
    output ramAddr_t  ldAddr,
    output word_t     ldData,
    output logic      booted
);

    localparam int HoldWidth = $clog2(`RESET_CYCLES + 1);

    loaderState_t         state;
    logic [HoldWidth-1:0] holdCnt;
    cardAddr_t            remaining;

    // RAM port stays with the loader until the image is in
    assign loading = !booted;

    always_ff @(posedge clk_25mhz) begin
        if (!rstN) begin
            state     <= RESET_HOLD;
            holdCnt   <= '0;
            remaining <= '0;
            sdRead    <= 1'b0;
            sdAddr    <= '0;
            ldWrite   <= 1'b0;
            booted    <= 1'b0;
        end else begin
            sdRead  <= 1'b0;
            ldWrite <= 1'b0;
            case (state)
                RESET_HOLD: begin
                    holdCnt <= holdCnt + 1'b1;
                    if (holdCnt == HoldWidth'(`RESET_CYCLES - 1)) begin
                        state <= READ_SIZE;
                    end
                end
                READ_SIZE: begin
                    // Image header sits at card word 0
                    if (!sdBusy) begin
                        sdRead <= 1'b1;
                        sdAddr <= '0;
                        state  <= WAIT_SIZE;
                    end
                end
                WAIT_SIZE: begin
                    if (sdDone) begin
                        remaining <= cardAddr_t'(sdData);
                        state     <= (sdData == '0) ? RUNNING : READ_WORD;
                    end
                end
                READ_WORD: begin
                    if (!sdBusy) begin
                        sdRead <= 1'b1;
                        sdAddr <= sdAddr + 1'b1;
                        state  <= WAIT_WORD;
                    end
                end
                WAIT_WORD: begin
                    if (sdDone) begin
                        // Card word k lands at RAM word k-1
                        ldWrite   <= 1'b1;
                        ldAddr    <= ramAddr_t'(sdAddr - 1'b1);
                        ldData    <= sdData;
                        remaining <= remaining - 1'b1;
                        state     <= (remaining == cardAddr_t'(1)) ? RUNNING : READ_WORD;
                    end
                end
                RUNNING: begin
                    booted <= 1'b1;
                end
                default: state <= RESET_HOLD;
            endcase
        end
    end

    // Image must fit in program RAM
    sizeFits: assert property (@(posedge clk_25mhz) disable iff (!rstN)
        (state == WAIT_SIZE && sdDone) |-> (sdData <= word_t'(`RAM_WORDS)));

endmodule

/* hw/bootSystem.sv */
`timescale 1ns/10ps

module bootSystem
    import memPkg::*;
(
    input  logic     clk_25mhz,
    input  logic     rstN,
    input  busAddr_t busAddr,
    input  word_t    busWrData,
    input  logic     busWrite,
    input  coord_t   scanX,
    input  coord_t   scanY,
    input  logic     sdMiso,
    output word_t    busRdData,
    output pixel_t   scanPixel,
    output logic     booted,
    output logic     sdCs,
    output logic     sdClk,
    output logic     sdMosi
);

    // Card reader handshake
    logic      sdRead;
    cardAddr_t sdAddr;
    word_t     sdData;
    logic      sdBusy;
    logic      sdDone;

    // Loader side of the RAM port
    logic     loading;
    logic     ldWrite;
    ramAddr_t ldAddr;
    word_t    ldData;

    // Decoded memory ports
    logic     ramWrite;
    ramAddr_t ramAddr;
    word_t    ramWrData;
    logic     fbWrite;
    coord_t   fbX;
    coord_t   fbY;
    pixel_t   fbColor;

    sdReader sdReaderInst (
        .clk_25mhz (clk_25mhz),
        .rstN      (rstN),
        .read      (sdRead),
        .addr      (sdAddr),
        .miso      (sdMiso),
        .data      (sdData),
        .busy      (sdBusy),
        .done      (sdDone),
        .cs        (sdCs),
        .sclk      (sdClk),
        .mosi      (sdMosi)
    );

    bootLoader bootLoaderInst (
        .clk_25mhz (clk_25mhz),
        .rstN      (rstN),
        .sdBusy    (sdBusy),
        .sdDone    (sdDone),
        .sdData    (sdData),
        .sdRead    (sdRead),
        .sdAddr    (sdAddr),
        .loading   (loading),
        .ldWrite   (ldWrite),
        .ldAddr    (ldAddr),
        .ldData    (ldData),
        .booted    (booted)
    );

    memoryMap memoryMapInst (
        .clk_25mhz (clk_25mhz),
        .loading   (loading),
        .ldWrite   (ldWrite),
        .ldAddr    (ldAddr),
        .ldData    (ldData),
        .busAddr   (busAddr),
        .busWrData (busWrData),
        .busWrite  (busWrite),
        .ramWrite  (ramWrite),
        .ramAddr   (ramAddr),
        .ramWrData (ramWrData),
        .fbWrite   (fbWrite),
        .fbX       (fbX),
        .fbY       (fbY),
        .fbColor   (fbColor)
    );

    wordRam wordRamInst (
        .clk_25mhz (clk_25mhz),
        .write     (ramWrite),
        .addr      (ramAddr),
        .wrData    (ramWrData),
        .rdData    (busRdData)
    );

    frameBuffer frameBufferInst (
        .clk_25mhz (clk_25mhz),
        .write     (fbWrite),
        .x         (fbX),
        .y         (fbY),
        .color     (fbColor),
        .scanX     (scanX),
        .scanY     (scanY),
        .scanPixel (scanPixel)
    );

endmodule

/* hw/ctrlPkg.sv */
package ctrlPkg;

    // Boot sequencer
    typedef enum logic [2:0] {
        RESET_HOLD,
        READ_SIZE,
        WAIT_SIZE,
        READ_WORD,
        WAIT_WORD,
        RUNNING
    } loaderState_t;

    // SPI word reader
    typedef enum logic [1:0] {
        IDLE,
        SEND,
        RECEIVE,
        FINISH
    } sdState_t;

endpackage

/* hw/frameBuffer.sv */
`timescale 1ns/10ps

module frameBuffer
    import memPkg::*;
(
    input  logic   clk_25mhz,
    input  logic   write,
    input  coord_t x,
    input  coord_t y,
    input  pixel_t color,
    input  coord_t scanX,
    input  coord_t scanY,
    output pixel_t scanPixel
);

    localparam int Pixels = 256 * 256;

    pixel_t      mem [Pixels];
    logic [15:0] wrIndex;
    logic [15:0] rdIndex;

    // Row major, y selects the line
    assign wrIndex = {y, x};
    assign rdIndex = {scanY, scanX};

    always_ff @(posedge clk_25mhz) begin
        if (write) begin
            mem[wrIndex] <= color;
        end
    end

    // Scan-out port independent of the write side
    always_ff @(posedge clk_25mhz) begin
        scanPixel <= mem[rdIndex];
    end

endmodule

/* hw/memPkg.sv */
`include "bootCfg.svh"

package memPkg;

    // Data and address as seen on the processor bus
    typedef logic [31:0] word_t;
    typedef logic [31:0] busAddr_t;

    // Word index into program RAM
    typedef logic [$clog2(`RAM_WORDS)-1:0] ramAddr_t;

    // Word index into the card image
    typedef logic [15:0] cardAddr_t;

    // Framebuffer coordinates and 8-bit colour
    typedef logic [7:0] coord_t;
    typedef logic [7:0] pixel_t;

endpackage

/* hw/memoryMap.sv */
`timescale 1ns/10ps

module memoryMap
    import memPkg::*;
(
    input  logic     clk_25mhz,
    input  logic     loading,
    input  logic     ldWrite,
    input  ramAddr_t ldAddr,
    input  word_t    ldData,
    input  busAddr_t busAddr,
    input  word_t    busWrData,
    input  logic     busWrite,
    output logic     ramWrite,
    output ramAddr_t ramAddr,
    output word_t    ramWrData,
    output logic     fbWrite,
    output coord_t   fbX,
    output coord_t   fbY,
    output pixel_t   fbColor
);

    logic ramSel;
    logic pixelSel;

    // Upper half zero selects RAM, lower half zero with nonzero upper is a pixel
    assign ramSel   = (busAddr[31:16] == '0);
    assign pixelSel = (busAddr[15:0] == '0) && !ramSel;

    // Loader owns the RAM port during boot
    assign ramAddr   = loading ? ldAddr : ramAddr_t'(busAddr);
    assign ramWrData = loading ? ldData : busWrData;
    assign ramWrite  = loading ? ldWrite : (busWrite && ramSel);

    assign fbWrite = !loading && busWrite && pixelSel;
    assign fbX     = busAddr[23:16];
    assign fbY     = busAddr[31:24];
    assign fbColor = busWrData[7:0];

    // One bus write never reaches both memories
    exclusiveWrite: assert property (@(posedge clk_25mhz)
        !(ramWrite && fbWrite));

endmodule

/* hw/sdReader.sv */
`timescale 1ns/10ps
`include "bootCfg.svh"

module sdReader
    import memPkg::*;
    import ctrlPkg::*;
(
    input  logic      clk_25mhz,
    input  logic      rstN,
    input  logic      read,
    input  cardAddr_t addr,
    input  logic      miso,
    output word_t     data,
    output logic      busy,
    output logic      done,
    output logic      cs,
    output logic      sclk,
    output logic      mosi
);

    localparam int DivWidth = $clog2(`SPI_HALF_PERIOD + 1);
    localparam int CmdBits = 24;
    localparam int TotalBits = 56;
    localparam logic [7:0] ReadCmd = `SD_READ_CMD;

    sdState_t            state;
    logic [DivWidth-1:0] divCnt;
    logic [5:0]          bitCnt;
    logic [CmdBits-1:0]  txShift;
    word_t               rxShift;
    logic                halfTick;

    // End of one sclk half period
    assign halfTick = (divCnt == DivWidth'(`SPI_HALF_PERIOD - 1));

    always_ff @(posedge clk_25mhz) begin
        if (!rstN) begin
            state  <= IDLE;
            busy   <= 1'b0;
            done   <= 1'b0;
            cs     <= 1'b1;
            sclk   <= 1'b0;
            mosi   <= 1'b0;
            divCnt <= '0;
            bitCnt <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (read) begin
                        state   <= SEND;
                        busy    <= 1'b1;
                        cs      <= 1'b0;
                        divCnt  <= '0;
                        bitCnt  <= '0;
                        txShift <= {ReadCmd, addr};
                        // First bit must be on mosi before the first rising edge
                        mosi    <= ReadCmd[7];
                    end
                end
                SEND, RECEIVE: begin
                    divCnt <= halfTick ? '0 : divCnt + 1'b1;
                    if (halfTick) begin
                        sclk <= !sclk;
                        if (!sclk) begin
                            // Rising edge, card data is stable here
                            if (state == RECEIVE) begin
                                rxShift <= {rxShift[30:0], miso};
                            end
                        end else begin
                            // Falling edge closes a bit
                            bitCnt <= bitCnt + 1'b1;
                            if (state == SEND) begin
                                txShift <= {txShift[CmdBits-2:0], 1'b0};
                                mosi    <= txShift[CmdBits-2];
                                if (bitCnt == 6'(CmdBits - 1)) begin
                                    state <= RECEIVE;
                                    mosi  <= 1'b0;
                                end
                            end else if (bitCnt == 6'(TotalBits - 1)) begin
                                state <= FINISH;
                            end
                        end
                    end
                end
                FINISH: begin
                    state <= IDLE;
                    cs    <= 1'b1;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    data  <= rxShift;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // The loader has to wait for busy to fall before the next request
    readWhileBusy: assert property (@(posedge clk_25mhz) disable iff (!rstN)
        read |-> !busy);

    // sclk only moves inside a selected transfer
    sclkWithCs: assert property (@(posedge clk_25mhz) disable iff (!rstN)
        $changed(sclk) |-> !cs);

endmodule

/* hw/wordRam.sv */
`timescale 1ns/10ps
`include "bootCfg.svh"

module wordRam
    import memPkg::*;
(
    input  logic     clk_25mhz,
    input  logic     write,
    input  ramAddr_t addr,
    input  word_t    wrData,
    output word_t    rdData
);

    word_t mem [`RAM_WORDS];

    // Read sees the old word when written in the same cycle
    always_ff @(posedge clk_25mhz) begin
        if (write) begin
            mem[addr] <= wrData;
        end
        rdData <= mem[addr];
    end

endmodule
